// File: verilog/axo_defs.svh
/*
 * Axolotl core constants.
 * Reset vector, datapath sizes and the RV32I opcode and funct3 encodings.
 */
`ifndef AXO_DEFS_SVH
`define AXO_DEFS_SVH

// Reset vector.
`define AXO_ENTRYPOINT 32'h0000_0000

// Datapath width and register count.
`define AXO_XLEN  32
`define AXO_NREGS 32

// Major opcodes kept by this core.
`define AXO_OP_OP     7'b0110011
`define AXO_OP_OP_IMM 7'b0010011
`define AXO_OP_LUI    7'b0110111
`define AXO_OP_AUIPC  7'b0010111
`define AXO_OP_JAL    7'b1101111
`define AXO_OP_JALR   7'b1100111
`define AXO_OP_BRANCH 7'b1100011
`define AXO_OP_STORE  7'b0100011

// Conditional branch funct3.
`define AXO_F3_BEQ  3'b000
`define AXO_F3_BNE  3'b001
`define AXO_F3_BLT  3'b100
`define AXO_F3_BGE  3'b101
`define AXO_F3_BLTU 3'b110
`define AXO_F3_BGEU 3'b111

// ALU funct3, shared by OP and OP-IMM.
`define AXO_F3_ADD  3'b000
`define AXO_F3_SLL  3'b001
`define AXO_F3_SLT  3'b010
`define AXO_F3_SLTU 3'b011
`define AXO_F3_XOR  3'b100
`define AXO_F3_SR   3'b101
`define AXO_F3_OR   3'b110
`define AXO_F3_AND  3'b111

`endif

// File: verilog/axo_isa_pkg.sv
/*
 * Axolotl architectural types.
 * Vector types for data words, addresses, instructions and register numbers.
 */
`include "axo_defs.svh"

package axo_isa_pkg;

    // One XLEN data word.
    typedef logic [`AXO_XLEN-1:0] word_t;

    // Instruction address, byte granular.
    typedef logic [`AXO_XLEN-1:0] pc_t;

    // Raw 32-bit instruction, no compressed forms.
    typedef logic [31:0] insn_t;

    // Register number, x0 is the hard zero.
    typedef logic [$clog2(`AXO_NREGS)-1:0] reg_idx_t;

endpackage

// File: verilog/axo_pipe_pkg.sv
/*
 * Axolotl pipeline types.
 * ALU operation codes passed from decode to execute.
 */
package axo_pipe_pkg;

    // ALU operation selector.
    typedef logic [3:0] alu_op_t;

    // Arithmetic and logic.
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SLT  = 4'd3;
    localparam alu_op_t ALU_SLTU = 4'd4;
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_AND  = 4'd9;

    // Branch compares, the result lands in bit 0.
    localparam alu_op_t ALU_EQ   = 4'd10;
    localparam alu_op_t ALU_NE   = 4'd11;
    localparam alu_op_t ALU_LT   = 4'd12;
    localparam alu_op_t ALU_GE   = 4'd13;
    localparam alu_op_t ALU_LTU  = 4'd14;
    localparam alu_op_t ALU_GEU  = 4'd15;

endpackage

// File: verilog/axo_id_ex_if.sv
/*
 * Decode to execute barrier bundle.
 * Decode drives it from its registers, execute consumes it.
 */
`timescale 1ns/1ps

interface axo_id_ex_if;

    // Slot holds a live instruction.
    logic                  valid;
    // Destination, 0 means no write-back.
    axo_isa_pkg::reg_idx_t rd;
    // ALU operands.
    axo_isa_pkg::word_t    lhs;
    axo_isa_pkg::word_t    rhs;
    axo_pipe_pkg::alu_op_t alu_op;
    // Store payload, address is lhs plus store_off.
    logic                  is_store;
    axo_isa_pkg::word_t    store_data;
    axo_isa_pkg::word_t    store_off;
    // Conditional branch, with the predicted direction and the other path.
    logic                  is_branch;
    logic                  predict;
    axo_isa_pkg::pc_t      alt_pc;

    modport src (
        output valid, rd, lhs, rhs, alu_op,
        output is_store, store_data, store_off,
        output is_branch, predict, alt_pc
    );

    modport dst (
        input valid, rd, lhs, rhs, alu_op,
        input is_store, store_data, store_off,
        input is_branch, predict, alt_pc
    );

endinterface

// File: verilog/axo_fetch.sv
/*
 * Fetch stage.
 * Program counter, program bus requests and the IF/ID barrier.
 */
`timescale 1ns/1ps
`include "axo_defs.svh"

module axo_fetch (
    input  logic                clk,
    input  logic                rst_latch,
    input  logic                hold,
    input  logic                flush,
    input  axo_isa_pkg::pc_t    redirect_pc,
    input  logic                jump,
    input  axo_isa_pkg::pc_t    jump_pc,
    input  logic                prog_ready,
    input  axo_isa_pkg::insn_t  prog_data,
    output logic                prog_re,
    output axo_isa_pkg::pc_t    prog_addr,
    output logic                ifid_valid,
    output axo_isa_pkg::pc_t    ifid_pc,
    output axo_isa_pkg::insn_t  ifid_insn
);

    axo_isa_pkg::pc_t pc;
    axo_isa_pkg::pc_t pc_next;

    // Bus request follows the PC directly.
    assign prog_re   = !rst_latch && !hold;
    assign prog_addr = pc;

    // Misprediction beats a decode jump, which beats sequential flow.
    always_comb begin
        if (flush) begin
            pc_next = redirect_pc;
        end else if (jump) begin
            pc_next = jump_pc;
        end else if (prog_ready) begin
            pc_next = pc + 32'd4;
        end else begin
            // Bus stalled, retry same address.
            pc_next = pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_latch) begin
            pc         <= `AXO_ENTRYPOINT;
            ifid_valid <= 1'b0;
        end else if (!hold) begin
            pc <= pc_next;
            // Bubble on stall; redirects squash the word just fetched.
            ifid_valid <= prog_ready && !flush && !jump;
        end
    end

    // Instruction payload.
    always_ff @(posedge clk) begin
        if (!hold) begin
            ifid_pc   <= pc;
            ifid_insn <= prog_data;
        end
    end

endmodule

// File: verilog/axo_regfile.sv
/*
 * Integer register file.
 * x1 to x31 with two asynchronous reads and one synchronous write.
 */
`timescale 1ns/1ps
`include "axo_defs.svh"

module axo_regfile (
    input  logic                   clk,
    input  logic                   rst_latch,
    input  axo_isa_pkg::reg_idx_t  rs1,
    input  axo_isa_pkg::reg_idx_t  rs2,
    input  axo_isa_pkg::reg_idx_t  wr_rd,
    input  axo_isa_pkg::word_t     wr_data,
    output axo_isa_pkg::word_t     rs1_val,
    output axo_isa_pkg::word_t     rs2_val
);

    // No storage behind x0.
    axo_isa_pkg::word_t regs [1:`AXO_NREGS-1];

    always_ff @(posedge clk) begin
        if (rst_latch) begin
            for (int i = 1; i < `AXO_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_rd != '0) begin
            // rd of 0 doubles as write disable.
            regs[wr_rd] <= wr_data;
        end
    end

    // x0 reads zero.
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: verilog/axo_decode.sv
/*
 * Decode stage.
 * Field and immediate extraction, operand forwarding, jump resolution,
 * static branch prediction and the ID/EX barrier.
 */
`timescale 1ns/1ps
`include "axo_defs.svh"

module axo_decode (
    input  logic                   clk,
    input  logic                   rst_latch,
    input  logic                   hold,
    input  logic                   flush,
    input  logic                   ifid_valid,
    input  axo_isa_pkg::pc_t       ifid_pc,
    input  axo_isa_pkg::insn_t     ifid_insn,
    input  axo_isa_pkg::reg_idx_t  wb_rd,
    input  axo_isa_pkg::word_t     wb_data,
    output logic                   jump,
    output axo_isa_pkg::pc_t       jump_pc,
    axo_id_ex_if.src               id_ex
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    axo_isa_pkg::reg_idx_t rs1;
    axo_isa_pkg::reg_idx_t rs2;
    axo_isa_pkg::reg_idx_t rd;
    logic                  is_op;
    logic                  is_op_imm;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  is_branch;
    logic                  is_store;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  has_rd;
    axo_isa_pkg::word_t    imm_i;
    axo_isa_pkg::word_t    imm_s;
    axo_isa_pkg::word_t    imm_b;
    axo_isa_pkg::word_t    imm_u;
    axo_isa_pkg::word_t    imm_j;
    axo_isa_pkg::word_t    rf_rs1;
    axo_isa_pkg::word_t    rf_rs2;
    axo_isa_pkg::word_t    rs1_val;
    axo_isa_pkg::word_t    rs2_val;
    axo_isa_pkg::word_t    lhs;
    axo_isa_pkg::word_t    rhs;
    axo_pipe_pkg::alu_op_t alu_op;
    axo_isa_pkg::pc_t      link;
    axo_isa_pkg::pc_t      target;
    logic                  predict;

    // Fixed field positions.
    assign opcode = ifid_insn[6:0];
    assign funct3 = ifid_insn[14:12];
    assign rd     = ifid_insn[11:7];
    assign rs1    = ifid_insn[19:15];
    assign rs2    = ifid_insn[24:20];

    assign is_op     = opcode == `AXO_OP_OP;
    assign is_op_imm = opcode == `AXO_OP_OP_IMM;
    assign is_jal    = opcode == `AXO_OP_JAL;
    assign is_jalr   = opcode == `AXO_OP_JALR;
    assign is_branch = opcode == `AXO_OP_BRANCH;
    assign is_store  = opcode == `AXO_OP_STORE;

    // Register usage per opcode.
    assign use_rs1 = is_op || is_op_imm || is_jalr || is_branch || is_store;
    assign use_rs2 = is_op || is_branch || is_store;
    assign has_rd  = is_op || is_op_imm || is_jal || is_jalr
                  || opcode == `AXO_OP_LUI || opcode == `AXO_OP_AUIPC;

    // Sign-extended immediates.
    assign imm_i = {{20{ifid_insn[31]}}, ifid_insn[31:20]};
    assign imm_s = {{20{ifid_insn[31]}}, ifid_insn[31:25], ifid_insn[11:7]};
    assign imm_b = {{19{ifid_insn[31]}}, ifid_insn[31], ifid_insn[7],
                    ifid_insn[30:25], ifid_insn[11:8], 1'b0};
    assign imm_u = {ifid_insn[31:12], 12'h000};
    assign imm_j = {{11{ifid_insn[31]}}, ifid_insn[31], ifid_insn[19:12],
                    ifid_insn[20], ifid_insn[30:21], 1'b0};

    axo_regfile u_regfile (
        .clk       (clk),
        .rst_latch (rst_latch),
        .rs1       (rs1),
        .rs2       (rs2),
        .wr_rd     (wb_rd),
        .wr_data   (wb_data),
        .rs1_val   (rf_rs1),
        .rs2_val   (rf_rs2)
    );

    // Bypass the result execute is writing this cycle.
    assign rs1_val = (use_rs1 && rs1 != '0 && wb_rd == rs1) ? wb_data : rf_rs1;
    assign rs2_val = (use_rs2 && rs2 != '0 && wb_rd == rs2) ? wb_data : rf_rs2;

    // Operand selection.
    always_comb begin
        lhs = rs1_val;
        rhs = rs2_val;
        if (is_op_imm) begin
            rhs = imm_i;
        end else if (opcode == `AXO_OP_LUI) begin
            lhs = '0;
            rhs = imm_u;
        end else if (opcode == `AXO_OP_AUIPC) begin
            lhs = ifid_pc;
            rhs = imm_u;
        end else if (is_jal || is_jalr) begin
            // Link value pc+4 through the adder.
            lhs = ifid_pc;
            rhs = 32'd4;
        end
    end

    // ALU operation.
    always_comb begin
        alu_op = axo_pipe_pkg::ALU_ADD;
        if (is_branch) begin
            case (funct3)
                `AXO_F3_BNE:  alu_op = axo_pipe_pkg::ALU_NE;
                `AXO_F3_BLT:  alu_op = axo_pipe_pkg::ALU_LT;
                `AXO_F3_BGE:  alu_op = axo_pipe_pkg::ALU_GE;
                `AXO_F3_BLTU: alu_op = axo_pipe_pkg::ALU_LTU;
                `AXO_F3_BGEU: alu_op = axo_pipe_pkg::ALU_GEU;
                default:      alu_op = axo_pipe_pkg::ALU_EQ;
            endcase
        end else if (is_op || is_op_imm) begin
            case (funct3)
                // SUB only exists in register form.
                `AXO_F3_ADD: alu_op = (is_op && ifid_insn[30]) ? axo_pipe_pkg::ALU_SUB
                                                                : axo_pipe_pkg::ALU_ADD;
                `AXO_F3_SLL:  alu_op = axo_pipe_pkg::ALU_SLL;
                `AXO_F3_SLT:  alu_op = axo_pipe_pkg::ALU_SLT;
                `AXO_F3_SLTU: alu_op = axo_pipe_pkg::ALU_SLTU;
                `AXO_F3_XOR:  alu_op = axo_pipe_pkg::ALU_XOR;
                `AXO_F3_SR:   alu_op = ifid_insn[30] ? axo_pipe_pkg::ALU_SRA
                                                     : axo_pipe_pkg::ALU_SRL;
                `AXO_F3_OR:   alu_op = axo_pipe_pkg::ALU_OR;
                default:      alu_op = axo_pipe_pkg::ALU_AND;
            endcase
        end
    end

    // One adder for JAL, JALR and branch targets.
    assign target  = (is_jalr ? rs1_val : ifid_pc)
                   + (is_jal ? imm_j : (is_jalr ? imm_i : imm_b));
    assign link    = ifid_pc + 32'd4;
    // Backward taken, forward not taken.
    assign predict = imm_b[31];

    // Redirect fetch, unless this slot is being flushed.
    assign jump    = ifid_valid && !flush && (is_jal || is_jalr || (is_branch && predict));
    assign jump_pc = {target[31:1], 1'b0};

    always_ff @(posedge clk) begin
        if (rst_latch) begin
            id_ex.valid <= 1'b0;
        end else if (!hold) begin
            id_ex.valid <= ifid_valid && !flush;
        end
    end

    // Decoded payload.
    always_ff @(posedge clk) begin
        if (!hold) begin
            id_ex.rd         <= has_rd ? rd : '0;
            id_ex.lhs        <= lhs;
            id_ex.rhs        <= rhs;
            id_ex.alu_op     <= alu_op;
            id_ex.is_store   <= is_store;
            id_ex.store_data <= rs2_val;
            id_ex.store_off  <= imm_s;
            id_ex.is_branch  <= is_branch;
            id_ex.predict    <= predict;
            // Path not taken by the prediction.
            id_ex.alt_pc     <= predict ? link : target;
        end
    end

endmodule

// File: verilog/axo_execute.sv
/*
 * Execute stage.
 * ALU, branch resolution, store bus and register write-back.
 */
`timescale 1ns/1ps

module axo_execute (
    input  logic                   clk,
    input  logic                   rst_latch,
    input  logic                   mem_ready,
    axo_id_ex_if.dst               id_ex,
    output logic                   hold,
    output logic                   flush,
    output axo_isa_pkg::pc_t       redirect_pc,
    output axo_isa_pkg::reg_idx_t  wb_rd,
    output axo_isa_pkg::word_t     wb_data,
    output logic                   mem_we,
    output axo_isa_pkg::word_t     mem_addr,
    output axo_isa_pkg::word_t     mem_wdata
);

    axo_isa_pkg::word_t alu_res;
    logic [4:0]         shamt;
    logic               mispredict;
    logic               redirect_q;

    assign shamt = id_ex.rhs[4:0];

    always_comb begin
        case (id_ex.alu_op)
            axo_pipe_pkg::ALU_ADD:  alu_res = id_ex.lhs + id_ex.rhs;
            axo_pipe_pkg::ALU_SUB:  alu_res = id_ex.lhs - id_ex.rhs;
            axo_pipe_pkg::ALU_SLL:  alu_res = id_ex.lhs << shamt;
            axo_pipe_pkg::ALU_SLT:  alu_res = {31'b0, $signed(id_ex.lhs) < $signed(id_ex.rhs)};
            axo_pipe_pkg::ALU_SLTU: alu_res = {31'b0, id_ex.lhs < id_ex.rhs};
            axo_pipe_pkg::ALU_XOR:  alu_res = id_ex.lhs ^ id_ex.rhs;
            axo_pipe_pkg::ALU_SRL:  alu_res = id_ex.lhs >> shamt;
            axo_pipe_pkg::ALU_SRA:  alu_res = $unsigned($signed(id_ex.lhs) >>> shamt);
            axo_pipe_pkg::ALU_OR:   alu_res = id_ex.lhs | id_ex.rhs;
            axo_pipe_pkg::ALU_AND:  alu_res = id_ex.lhs & id_ex.rhs;
            // Compares for branches.
            axo_pipe_pkg::ALU_EQ:   alu_res = {31'b0, id_ex.lhs == id_ex.rhs};
            axo_pipe_pkg::ALU_NE:   alu_res = {31'b0, id_ex.lhs != id_ex.rhs};
            axo_pipe_pkg::ALU_LT:   alu_res = {31'b0, $signed(id_ex.lhs) < $signed(id_ex.rhs)};
            axo_pipe_pkg::ALU_GE:   alu_res = {31'b0, $signed(id_ex.lhs) >= $signed(id_ex.rhs)};
            axo_pipe_pkg::ALU_LTU:  alu_res = {31'b0, id_ex.lhs < id_ex.rhs};
            default:                alu_res = {31'b0, id_ex.lhs >= id_ex.rhs};
        endcase
    end

    // Store port, stable until mem_ready.
    assign mem_we    = id_ex.valid && id_ex.is_store;
    assign mem_addr  = id_ex.lhs + id_ex.store_off;
    assign mem_wdata = id_ex.store_data;
    // Freeze the whole pipe under store back-pressure.
    assign hold      = mem_we && !mem_ready;

    // Outcome in bit 0 against the decode guess.
    assign mispredict  = id_ex.valid && id_ex.is_branch && (alu_res[0] != id_ex.predict);
    // One redirect per resolved branch.
    assign flush       = mispredict && !redirect_q;
    assign redirect_pc = id_ex.alt_pc;

    always_ff @(posedge clk) begin
        if (rst_latch) begin
            redirect_q <= 1'b0;
        end else begin
            redirect_q <= flush;
        end
    end

    // No write-back for stores, branches or a held slot.
    assign wb_rd   = (id_ex.valid && !id_ex.is_store && !id_ex.is_branch && !hold)
                   ? id_ex.rd : '0;
    assign wb_data = alu_res;

endmodule

// File: verilog/axo_core.sv
/*
 * Axolotl RV32I core, three stages.
 * Fetch, decode and execute joined to the program and store buses.
 */
`timescale 1ns/1ps

module axo_core (
    input  logic                clk,
    input  logic                rst_latch,
    // Program bus.
    output logic                prog_re,
    output axo_isa_pkg::pc_t    prog_addr,
    input  logic                prog_ready,
    input  axo_isa_pkg::insn_t  prog_data,
    // Store bus, write only.
    output logic                mem_we,
    output axo_isa_pkg::word_t  mem_addr,
    output axo_isa_pkg::word_t  mem_wdata,
    input  logic                mem_ready
);

    logic                  hold;
    logic                  flush;
    axo_isa_pkg::pc_t      redirect_pc;
    logic                  jump;
    axo_isa_pkg::pc_t      jump_pc;
    logic                  ifid_valid;
    axo_isa_pkg::pc_t      ifid_pc;
    axo_isa_pkg::insn_t    ifid_insn;
    axo_isa_pkg::reg_idx_t wb_rd;
    axo_isa_pkg::word_t    wb_data;

    axo_id_ex_if id_ex ();

    axo_fetch u_fetch (
        .clk         (clk),
        .rst_latch   (rst_latch),
        .hold        (hold),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .jump        (jump),
        .jump_pc     (jump_pc),
        .prog_ready  (prog_ready),
        .prog_data   (prog_data),
        .prog_re     (prog_re),
        .prog_addr   (prog_addr),
        .ifid_valid  (ifid_valid),
        .ifid_pc     (ifid_pc),
        .ifid_insn   (ifid_insn)
    );

    axo_decode u_decode (
        .clk        (clk),
        .rst_latch  (rst_latch),
        .hold       (hold),
        .flush      (flush),
        .ifid_valid (ifid_valid),
        .ifid_pc    (ifid_pc),
        .ifid_insn  (ifid_insn),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .jump       (jump),
        .jump_pc    (jump_pc),
        .id_ex      (id_ex.src)
    );

    axo_execute u_execute (
        .clk         (clk),
        .rst_latch   (rst_latch),
        .mem_ready   (mem_ready),
        .id_ex       (id_ex.dst),
        .hold        (hold),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata)
    );

endmodule

// File: test/axo_core_chk.sv
/*
 * Bound checker for the Axolotl core.
 * Reset state, program and store bus protocol, and stores against a table.
 */
`timescale 1ns/1ps
`include "axo_defs.svh"

module axo_core_chk (
    input logic                clk,
    input logic                rst_latch,
    input logic                prog_re,
    input axo_isa_pkg::pc_t    prog_addr,
    input logic                prog_ready,
    input logic                mem_we,
    input axo_isa_pkg::word_t  mem_addr,
    input axo_isa_pkg::word_t  mem_wdata,
    input logic                mem_ready,
    input logic                jump,
    input logic                flush
);

    localparam logic [3:0] N_STORES = 4'd13;

    // Hand-computed stores in program order.
    localparam axo_isa_pkg::word_t EXP_ADDR [0:12] = '{
        32'h100, 32'h104, 32'h108, 32'h10C, 32'h110, 32'h114, 32'h118,
        32'h11C, 32'h120, 32'h124, 32'h128, 32'h12C, 32'h130
    };
    localparam axo_isa_pkg::word_t EXP_DATA [0:12] = '{
        32'h0000_0002, 32'hFFFF_FFFD, 32'h0000_0050, 32'hFFFF_FFFE,
        32'h0000_000F, 32'h0000_0001, 32'h0000_0001, 32'h0000_00FD,
        32'h1234_5000, 32'h0000_1054, 32'h0000_0003, 32'h0000_0080,
        32'h0000_0090
    };

    logic [3:0]         store_count;
    logic               fail_seen = 1'b0;
    axo_isa_pkg::word_t exp_addr;
    axo_isa_pkg::word_t exp_data;

    function automatic string test_name(input logic [3:0] idx);
        case (idx)
            4'd0:    return "add";
            4'd1:    return "sub";
            4'd2:    return "slli";
            4'd3:    return "srai";
            4'd4:    return "srli";
            4'd5:    return "slt";
            4'd6:    return "sltu";
            4'd7:    return "xori_or_and";
            4'd8:    return "lui";
            4'd9:    return "auipc";
            4'd10:   return "backward_loop";
            4'd11:   return "jal_link";
            default: return "jalr_link";
        endcase
    endfunction

    // One completed write per mem_we with mem_ready.
    always_ff @(posedge clk) begin
        if (rst_latch) begin
            store_count <= 4'd0;
        end else if (mem_we && mem_ready) begin
            store_count <= store_count + 4'd1;
        end
    end

    always_comb begin
        exp_addr = '0;
        exp_data = '0;
        if (store_count < N_STORES) begin
            exp_addr = EXP_ADDR[store_count];
            exp_data = EXP_DATA[store_count];
        end
    end

    // First cycle out of reset.
    assert property (@(posedge clk) $fell(rst_latch) |->
                     (!mem_we && prog_addr == `AXO_ENTRYPOINT))
        else begin
            fail_seen = 1'b1;
            $error("CHECK FAILED reset: expected prog_addr %h mem_we 0, actual prog_addr %h mem_we %b",
                   `AXO_ENTRYPOINT, $sampled(prog_addr), $sampled(mem_we));
        end

    // Program reads pause only while a store waits for mem_ready.
    assert property (@(posedge clk) disable iff (rst_latch)
                     prog_re == !(mem_we && !mem_ready))
        else begin
            fail_seen = 1'b1;
            $error("prog_re did not follow the store bus back-pressure");
        end

    // Stalled program read keeps its address unless redirected.
    assert property (@(posedge clk) disable iff (rst_latch)
                     (prog_re && !prog_ready && !jump && !flush) |=> $stable(prog_addr))
        else begin
            fail_seen = 1'b1;
            $error("prog_addr moved while the program bus was stalled");
        end

    // Pending write keeps its address and data.
    assert property (@(posedge clk) disable iff (rst_latch)
                     (mem_we && !mem_ready) |=>
                     (mem_we && $stable(mem_addr) && $stable(mem_wdata)))
        else begin
            fail_seen = 1'b1;
            $error("Store bus dropped or changed a write before mem_ready");
        end

    // Nothing stores past the end of the table.
    assert property (@(posedge clk) disable iff (rst_latch)
                     (mem_we && mem_ready) |-> (store_count < N_STORES))
        else begin
            fail_seen = 1'b1;
            $error("Store to address %h after the last expected store", $sampled(mem_addr));
        end

    // Each completed store matches the table in order.
    assert property (@(posedge clk) disable iff (rst_latch)
                     (mem_we && mem_ready && store_count < N_STORES) |->
                     (mem_addr == exp_addr && mem_wdata == exp_data))
        else begin
            fail_seen = 1'b1;
            $error("CHECK FAILED %s: expected addr %h data %h, actual addr %h data %h",
                   test_name($sampled(store_count)), $sampled(exp_addr), $sampled(exp_data),
                   $sampled(mem_addr), $sampled(mem_wdata));
        end

endmodule

bind axo_core axo_core_chk u_chk (
    .clk        (clk),
    .rst_latch  (rst_latch),
    .prog_re    (prog_re),
    .prog_addr  (prog_addr),
    .prog_ready (prog_ready),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_ready  (mem_ready),
    .jump       (jump),
    .flush      (flush)
);

// File: test/axo_core_tb.sv
/*
 * Testbench for the Axolotl core.
 * Program ROM, random bus back-pressure and the final verdict.
 */
`timescale 1ns/1ps
`include "axo_defs.svh"

module axo_core_tb;

    localparam int unsigned TIMEOUT_CYCLES = 3000;
    localparam int unsigned DRAIN_CYCLES   = 40;
    localparam logic [3:0]  STORES_TOTAL   = 4'd13;

    logic               clk = 1'b0;
    logic               rst_latch;
    logic               prog_re;
    axo_isa_pkg::pc_t   prog_addr;
    logic               prog_ready = 1'b0;
    axo_isa_pkg::insn_t prog_data;
    logic               mem_we;
    axo_isa_pkg::word_t mem_addr;
    axo_isa_pkg::word_t mem_wdata;
    logic               mem_ready = 1'b0;
    axo_isa_pkg::insn_t rom [0:63];
    int                 rom_fill = 0;

    always #4 clk = ~clk;

    // ROM answers in the same cycle.
    assign prog_data = rom[prog_addr[7:2]];

    axo_core u_dut (
        .clk        (clk),
        .rst_latch  (rst_latch),
        .prog_re    (prog_re),
        .prog_addr  (prog_addr),
        .prog_ready (prog_ready),
        .prog_data  (prog_data),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_ready  (mem_ready)
    );

    // Each ready low about 30% of the time.
    always @(posedge clk) begin
        prog_ready <= ($urandom % 32'd10) >= 32'd3;
        mem_ready  <= ($urandom % 32'd10) >= 32'd3;
    end

    // RV32I encoders.
    function automatic axo_isa_pkg::insn_t alu_reg(input logic [6:0] f7, input logic [2:0] f3,
                                                   input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `AXO_OP_OP};
    endfunction

    function automatic axo_isa_pkg::insn_t alu_imm(input logic [6:0] op, input logic [2:0] f3,
                                                   input int rd, input int rs1,
                                                   input logic [31:0] imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic axo_isa_pkg::insn_t store_word(input int rs2, input int rs1,
                                                      input logic [31:0] imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `AXO_OP_STORE};
    endfunction

    function automatic axo_isa_pkg::insn_t cond_branch(input logic [2:0] f3, input int rs1,
                                                       input int rs2, input logic [31:0] off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11],
                `AXO_OP_BRANCH};
    endfunction

    function automatic axo_isa_pkg::insn_t upper_imm(input logic [6:0] op, input int rd,
                                                     input logic [31:0] imm);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic axo_isa_pkg::insn_t jump_link(input int rd, input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `AXO_OP_JAL};
    endfunction

    task automatic emit(input axo_isa_pkg::insn_t word);
        rom[rom_fill] = word;
        rom_fill++;
    endtask

    task automatic load_program();
        // 0x00, ALU chain with back-to-back dependencies.
        emit(alu_imm(`AXO_OP_OP_IMM, `AXO_F3_ADD, 1, 0, 5));
        emit(alu_imm(`AXO_OP_OP_IMM, `AXO_F3_ADD, 2, 0, -3));
        emit(alu_reg(7'h00, `AXO_F3_ADD, 3, 1, 2));
        emit(alu_reg(7'h20, `AXO_F3_ADD, 4, 3, 1));
        emit(store_word(3, 0, 32'h100));
        emit(store_word(4, 0, 32'h104));
        // 0x18, shifts.
        emit(alu_imm(`AXO_OP_OP_IMM, `AXO_F3_SLL, 5, 1, 4));
        emit(alu_imm(`AXO_OP_OP_IMM, `AXO_F3_SR, 6, 2, 32'h401));
        emit(alu_imm(`AXO_OP_OP_IMM, `AXO_F3_SR, 7, 2, 28));
        emit(store_word(5, 0, 32'h108));
        emit(store_word(6, 0, 32'h10C));
        emit(store_word(7, 0, 32'h110));
        // 0x30, compares and logic.
        emit(alu_reg(7'h00, `AXO_F3_SLT, 8, 2, 1));
        emit(alu_reg(7'h00, `AXO_F3_SLTU, 9, 1, 2));
        emit(store_word(8, 0, 32'h114));
        emit(store_word(9, 0, 32'h118));
        emit(alu_imm(`AXO_OP_OP_IMM, `AXO_F3_XOR, 10, 1, 32'hFF));
        emit(alu_reg(7'h00, `AXO_F3_OR, 11, 10, 1));
        emit(alu_reg(7'h00, `AXO_F3_AND, 12, 11, 2));
        emit(store_word(12, 0, 32'h11C));
        // 0x50, upper immediates.
        emit(upper_imm(`AXO_OP_LUI, 13, 32'h12345));
        emit(upper_imm(`AXO_OP_AUIPC, 14, 32'h1));
        emit(store_word(13, 0, 32'h120));
        emit(store_word(14, 0, 32'h124));
        // 0x60, three-pass backward loop.
        emit(alu_imm(`AXO_OP_OP_IMM, `AXO_F3_ADD, 16, 0, 3));
        emit(alu_imm(`AXO_OP_OP_IMM, `AXO_F3_ADD, 15, 0, 0));
        emit(alu_imm(`AXO_OP_OP_IMM, `AXO_F3_ADD, 15, 15, 1));
        emit(cond_branch(`AXO_F3_BNE, 15, 16, -4));
        emit(store_word(15, 0, 32'h128));
        // 0x74, forward branch taken against the prediction.
        emit(cond_branch(`AXO_F3_BEQ, 1, 1, 8));
        emit(store_word(1, 0, 32'h1FC));
        // 0x7C, JAL over one store.
        emit(jump_link(17, 8));
        emit(store_word(1, 0, 32'h1F8));
        emit(store_word(17, 0, 32'h12C));
        // 0x88, JALR on a base produced just before.
        emit(alu_imm(`AXO_OP_OP_IMM, `AXO_F3_ADD, 18, 0, 32'h9C));
        emit(alu_imm(`AXO_OP_JALR, 3'b000, 19, 18, 0));
        emit(store_word(1, 0, 32'h1F4));
        emit(store_word(1, 0, 32'h1F0));
        emit(store_word(1, 0, 32'h1EC));
        emit(store_word(19, 0, 32'h130));
        // Park here; the second word covers the fetch past the loop.
        emit(jump_link(0, 0));
        emit(jump_link(0, 0));
    endtask

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    initial begin
        int unsigned cycles;
        void'($urandom(32'h41aa_7760));
        rst_latch = 1'b1;
        load_program();
        repeat (16) @(posedge clk);
        rst_latch <= 1'b0;
        cycles = 0;
        while (u_dut.u_chk.store_count != STORES_TOTAL && !u_dut.u_chk.fail_seen
               && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (!u_dut.u_chk.fail_seen && u_dut.u_chk.store_count != STORES_TOTAL) begin
            stop_with_failure("Timed out waiting for the program's stores");
        end else begin
            // Give a stray store time to show up.
            cycles = 0;
            while (!u_dut.u_chk.fail_seen && cycles < DRAIN_CYCLES) begin
                @(posedge clk);
                cycles++;
            end
            if (u_dut.u_chk.fail_seen) begin
                stop_with_failure("A checker assertion failed");
            end else begin
                $display("Result: PASSED");
                $finish;
            end
        end
    end

endmodule

// File: verilog.f
+incdir+verilog
verilog/axo_isa_pkg.sv
verilog/axo_pipe_pkg.sv
verilog/axo_id_ex_if.sv
verilog/axo_fetch.sv
verilog/axo_regfile.sv
verilog/axo_decode.sv
verilog/axo_execute.sv
verilog/axo_core.sv
test/axo_core_chk.sv
test/axo_core_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := axo_core_tb
FILELIST  := verilog.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
